/* mem_subsystem.f */
hdl/mem_types_pkg.sv
hdl/arb_types_pkg.sv
hdl/mem_arbiter.sv
hdl/shared_ram.sv
hdl/mem_subsystem.sv
dv/mem_arbiter_assertions.sv
dv/mem_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=mem_subsystem_tb
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" \
  -f mem_subsystem.f -o "V$TOP" > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status, see $BUILD_LOG"
  exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$SIM_LOG"; then
  exit 0
fi
echo "Pass line not found in $SIM_LOG"
exit 1

/* dv/mem_subsystem_tb.sv */
`timescale 1ns/10ps

module mem_subsystem_tb
  import mem_types_pkg::*;
();

  localparam int NUM_PORTS   = 4;
  localparam int FILL_WORDS  = 16;
  localparam int STRB_WRITES = 8;
  localparam int RAND_TXNS   = 200;
  localparam int TOTAL_TXNS  = 2 * FILL_WORDS + STRB_WRITES + 2 * NUM_PORTS + 2 + RAND_TXNS;
  localparam int TIMEOUT_CYCLES = TOTAL_TXNS * 4 * RAM_LATENCY + 200;

  logic clock;
  logic reset;

  // Port slots follow the arbiter priority: dmem0, dmem1, imem0, imem1
  logic [NUM_PORTS-1:0] drv_valid;
  addr_t                drv_addr [NUM_PORTS];
  data_t                drv_wdata [NUM_PORTS];
  strb_t                drv_wstrb [NUM_PORTS];
  logic [NUM_PORTS-1:0] ready_vec;
  data_t                rdata_vec [NUM_PORTS];

  logic  imem0_ready, imem1_ready, dmem0_ready, dmem1_ready;
  data_t imem0_rdata, imem1_rdata, dmem0_rdata, dmem1_rdata;

  data_t                model_mem [RAM_WORDS];
  logic [NUM_PORTS-1:0] outstanding;
  int                   req_cycle [NUM_PORTS];
  int                   last_latency [NUM_PORTS];
  int                   done_order [$];
  int                   cycle_count = 0;
  int                   issue_count = 0;
  int                   done_count  = 0;
  int                   check_count = 0;
  int                   error_count = 0;
  string                test_name = "reset";

  mem_subsystem u_dut (
    .clock       (clock),
    .reset       (reset),
    .imem0_valid (drv_valid[2]),
    .imem0_addr  (drv_addr[2]),
    .imem0_ready (imem0_ready),
    .imem0_rdata (imem0_rdata),
    .imem1_valid (drv_valid[3]),
    .imem1_addr  (drv_addr[3]),
    .imem1_ready (imem1_ready),
    .imem1_rdata (imem1_rdata),
    .dmem0_valid (drv_valid[0]),
    .dmem0_addr  (drv_addr[0]),
    .dmem0_wdata (drv_wdata[0]),
    .dmem0_wstrb (drv_wstrb[0]),
    .dmem0_ready (dmem0_ready),
    .dmem0_rdata (dmem0_rdata),
    .dmem1_valid (drv_valid[1]),
    .dmem1_addr  (drv_addr[1]),
    .dmem1_wdata (drv_wdata[1]),
    .dmem1_wstrb (drv_wstrb[1]),
    .dmem1_ready (dmem1_ready),
    .dmem1_rdata (dmem1_rdata)
  );

  assign ready_vec = {imem1_ready, imem0_ready, dmem1_ready, dmem0_ready};
  assign rdata_vec = '{dmem0_rdata, dmem1_rdata, imem0_rdata, imem1_rdata};

  initial clock = 1'b0;
  always #2 clock = ~clock;

  // Returns the word as it was before the access, then applies the byte-masked write
  function automatic data_t model_access(addr_t addr, data_t wdata, strb_t wstrb);
    ram_index_t idx;
    data_t      old_word;
    idx      = addr[RAM_INDEX_W+1:2];
    old_word = model_mem[idx];
    for (int b = 0; b < STRB_W; b++) begin
      if (wstrb[b]) begin
        model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return old_word;
  endfunction

  // Low address bits are random since the RAM ignores them
  function automatic addr_t word_addr(int w);
    return addr_t'(32'h100 + 4 * w + $urandom_range(0, 3));
  endfunction

  task automatic check_value(string what, data_t expected, data_t actual);
    check_count++;
    assert (expected === actual) else begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // ==================================================
  // Scoreboard
  // ==================================================

  always @(posedge clock) begin
    data_t expected;
    cycle_count <= cycle_count + 1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (ready_vec[p]) begin
        assert (outstanding[p]) else begin
          $display("Port %0d gave a ready with no request outstanding in %s", p, test_name);
          error_count++;
        end
        if (outstanding[p]) begin
          expected = model_access(drv_addr[p], drv_wdata[p], drv_wstrb[p]);
          if (drv_wstrb[p] == '0) begin
            check_value($sformatf("port %0d rdata", p), expected, rdata_vec[p]);
          end
          last_latency[p] = cycle_count - req_cycle[p];
          outstanding[p]  = 1'b0;
        end
        done_order.push_back(p);
        done_count++;
      end
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================

  // Called on a falling edge and gives instruction ports no write fields
  task automatic drive_port(int p, addr_t addr, data_t wdata, strb_t wstrb);
    drv_valid[p]   = 1'b1;
    drv_addr[p]    = addr;
    drv_wdata[p]   = (p < 2) ? wdata : '0;
    drv_wstrb[p]   = (p < 2) ? wstrb : '0;
    outstanding[p] = 1'b1;
    req_cycle[p]   = cycle_count;
    issue_count++;
  endtask

  task automatic pulse_port(int p, addr_t addr, data_t wdata, strb_t wstrb);
    drive_port(p, addr, wdata, wstrb);
    @(negedge clock);
    drv_valid = '0;
  endtask

  task automatic wait_all();
    while (outstanding != '0) begin
      @(negedge clock);
    end
  endtask

  task automatic issue_and_wait(int p, addr_t addr, data_t wdata, strb_t wstrb);
    @(negedge clock);
    pulse_port(p, addr, wdata, wstrb);
    wait_all();
  endtask

  initial begin
    int    sent;
    strb_t strb;
    void'($urandom(32'hf721));
    reset       = 1'b0;
    drv_valid   = '0;
    outstanding = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      drv_addr[p]  = '0;
      drv_wdata[p] = '0;
      drv_wstrb[p] = '0;
    end
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    // Every word used later gets a full write first so no read sees undefined data
    test_name = "strobe_writes";
    for (int w = 0; w < FILL_WORDS; w++) begin
      issue_and_wait(w % 2, word_addr(w), data_t'($urandom), 4'hf);
    end
    for (int w = 0; w < STRB_WRITES; w++) begin
      strb = strb_t'($urandom_range(1, 14));
      issue_and_wait(w % 2, word_addr(2 * w), data_t'($urandom), strb);
    end
    for (int w = 0; w < FILL_WORDS; w++) begin
      issue_and_wait(w % NUM_PORTS, word_addr(w), '0, '0);
    end

    test_name = "single_latency";
    for (int p = 0; p < NUM_PORTS; p++) begin
      issue_and_wait(p, word_addr(p + 3), '0, '0);
      check_value($sformatf("port %0d latency", p), RAM_LATENCY, last_latency[p]);
    end

    test_name = "same_cycle_priority";
    done_order.delete();
    @(negedge clock);
    for (int p = 0; p < NUM_PORTS; p++) begin
      drive_port(p, word_addr(p + 8), '0, '0);
    end
    @(negedge clock);
    drv_valid = '0;
    wait_all();
    check_value("completions", NUM_PORTS, done_order.size());
    for (int i = 0; i < NUM_PORTS; i++) begin
      check_value($sformatf("completion %0d port", i), i, done_order[i]);
    end

    // dmem0 pulses one cycle after imem1 has been granted
    test_name = "no_preempt";
    done_order.delete();
    @(negedge clock);
    pulse_port(3, word_addr(5), '0, '0);
    pulse_port(0, word_addr(6), '0, '0);
    wait_all();
    check_value("completions", 2, done_order.size());
    check_value("first port", 3, done_order[0]);
    check_value("second port", 0, done_order[1]);

    test_name = "random_traffic";
    sent = 0;
    while (sent < RAND_TXNS) begin
      @(negedge clock);
      drv_valid = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (!outstanding[p] && sent < RAND_TXNS && $urandom_range(0, 1) == 1) begin
          strb = (p < 2 && $urandom_range(0, 1) == 1) ? strb_t'($urandom_range(1, 15)) : '0;
          drive_port(p, word_addr($urandom_range(0, FILL_WORDS - 1)), data_t'($urandom), strb);
          sent++;
        end
      end
    end
    @(negedge clock);
    drv_valid = '0;
    wait_all();
    check_value("requests completed", issue_count, done_count);

    $display("checks=%0d errors=%0d requests=%0d completions=%0d",
             check_count, error_count, issue_count, done_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Timed out after %0d cycles in %s with requests still waiting for ready",
             TIMEOUT_CYCLES, test_name);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* dv/mem_arbiter_assertions.sv */
`timescale 1ns/10ps

module mem_arbiter_assertions
  import mem_types_pkg::*, arb_types_pkg::*;
(
  input logic  clock,
  input logic  reset,
  input logic  dmem0_valid,
  input logic  dmem1_valid,
  input logic  imem0_valid,
  input logic  imem1_valid,
  input logic  dmem0_ready,
  input logic  dmem1_ready,
  input logic  imem0_ready,
  input logic  imem1_ready,
  input logic  mem_valid,
  input addr_t mem_addr,
  input data_t mem_wdata,
  input strb_t mem_wstrb,
  input logic  mem_ready
);

  logic [NUM_REQUESTERS-1:0] valid_vec;
  logic [NUM_REQUESTERS-1:0] ready_vec;
  logic [NUM_REQUESTERS-1:0] waiting_q;

  assign valid_vec = {imem1_valid, imem0_valid, dmem1_valid, dmem0_valid};
  assign ready_vec = {imem1_ready, imem0_ready, dmem1_ready, dmem0_ready};

  // A port waits from its valid pulse until its ready
  always_ff @(posedge clock) begin
    if (!reset) begin
      waiting_q <= '0;
    end else begin
      waiting_q <= (waiting_q | valid_vec) & ~ready_vec;
    end
  end

  one_ready: assert property (@(posedge clock) disable iff (!reset) $onehot0(ready_vec))
    else $error("More than one requester got ready in the same cycle");

  // The ready cycle may already carry the next grant
  bus_stable: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> mem_ready || (mem_valid && $stable(mem_addr)
      && $stable(mem_wdata) && $stable(mem_wstrb)))
    else $error("Memory request dropped or changed before mem_ready");

  for (genvar i = 0; i < NUM_REQUESTERS; i++) begin : g_port
    ready_owed: assert property (@(posedge clock) disable iff (!reset)
      ready_vec[i] |-> waiting_q[i])
      else $error("Requester %0d got ready without an outstanding request", i);
  end

endmodule

bind mem_arbiter mem_arbiter_assertions u_assertions (.*);

/* hdl/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem
  import mem_types_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  imem0_valid,
  input  addr_t imem0_addr,
  output logic  imem0_ready,
  output data_t imem0_rdata,
  input  logic  imem1_valid,
  input  addr_t imem1_addr,
  output logic  imem1_ready,
  output data_t imem1_rdata,
  input  logic  dmem0_valid,
  input  addr_t dmem0_addr,
  input  data_t dmem0_wdata,
  input  strb_t dmem0_wstrb,
  output logic  dmem0_ready,
  output data_t dmem0_rdata,
  input  logic  dmem1_valid,
  input  addr_t dmem1_addr,
  input  data_t dmem1_wdata,
  input  strb_t dmem1_wstrb,
  output logic  dmem1_ready,
  output data_t dmem1_rdata
);

  // Shared memory bus
  logic  mem_valid;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_wstrb;
  logic  mem_ready;
  data_t mem_rdata;

  mem_arbiter u_arbiter (
    .clock       (clock),
    .reset       (reset),
    .imem0_valid (imem0_valid),
    .imem0_addr  (imem0_addr),
    .imem0_ready (imem0_ready),
    .imem0_rdata (imem0_rdata),
    .imem1_valid (imem1_valid),
    .imem1_addr  (imem1_addr),
    .imem1_ready (imem1_ready),
    .imem1_rdata (imem1_rdata),
    .dmem0_valid (dmem0_valid),
    .dmem0_addr  (dmem0_addr),
    .dmem0_wdata (dmem0_wdata),
    .dmem0_wstrb (dmem0_wstrb),
    .dmem0_ready (dmem0_ready),
    .dmem0_rdata (dmem0_rdata),
    .dmem1_valid (dmem1_valid),
    .dmem1_addr  (dmem1_addr),
    .dmem1_wdata (dmem1_wdata),
    .dmem1_wstrb (dmem1_wstrb),
    .dmem1_ready (dmem1_ready),
    .dmem1_rdata (dmem1_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata)
  );

  shared_ram u_ram (
    .clock (clock),
    .reset (reset),
    .valid (mem_valid),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .wstrb (mem_wstrb),
    .ready (mem_ready),
    .rdata (mem_rdata)
  );

endmodule

/* hdl/shared_ram.sv */
`timescale 1ns/10ps

module shared_ram
  import mem_types_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  valid,
  input  addr_t addr,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  ready,
  output data_t rdata
);

  typedef enum logic {
    RAM_IDLE,
    RAM_WAIT
  } ram_state_t;

  ram_state_t state_q;
  lat_cnt_t   cnt_q;
  ram_index_t idx_q;
  data_t      wdata_q;
  strb_t      wstrb_q;
  logic       start;

  data_t mem [RAM_WORDS];

  // The arbiter may switch its fields during the ready cycle, so they are latched here
  assign start = (state_q == RAM_IDLE) && valid;
  assign ready = (state_q == RAM_WAIT) && (cnt_q == lat_cnt_t'(RAM_LATENCY));

  // ==================================================
  // Latency counter
  // ==================================================

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= RAM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        RAM_IDLE: begin
          if (valid) begin
            state_q <= RAM_WAIT;
            cnt_q   <= lat_cnt_t'(1);
          end
        end
        default: begin
          if (ready) begin
            state_q <= RAM_IDLE;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      idx_q   <= addr[RAM_INDEX_W+1:2];
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  // Write lands at the end of the ready cycle, so rdata shows the old word
  always_ff @(posedge clock) begin
    if (ready) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_q[b]) begin
          mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  assign rdata = mem[idx_q];

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter
  import mem_types_pkg::*, arb_types_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  imem0_valid,
  input  addr_t imem0_addr,
  output logic  imem0_ready,
  output data_t imem0_rdata,
  input  logic  imem1_valid,
  input  addr_t imem1_addr,
  output logic  imem1_ready,
  output data_t imem1_rdata,
  input  logic  dmem0_valid,
  input  addr_t dmem0_addr,
  input  data_t dmem0_wdata,
  input  strb_t dmem0_wstrb,
  output logic  dmem0_ready,
  output data_t dmem0_rdata,
  input  logic  dmem1_valid,
  input  addr_t dmem1_addr,
  input  data_t dmem1_wdata,
  input  strb_t dmem1_wstrb,
  output logic  dmem1_ready,
  output data_t dmem1_rdata,
  output logic  mem_valid,
  output addr_t mem_addr,
  output data_t mem_wdata,
  output strb_t mem_wstrb,
  input  logic  mem_ready,
  input  data_t mem_rdata
);

  // Incoming requests gathered into slots, slot 0 has the highest priority
  logic [NUM_REQUESTERS-1:0] in_valid;
  addr_t                     in_addr [NUM_REQUESTERS];
  data_t                     in_wdata [NUM_REQUESTERS];
  strb_t                     in_wstrb [NUM_REQUESTERS];

  logic [NUM_REQUESTERS-1:0] buf_valid_q;
  logic [NUM_REQUESTERS-1:0] buf_valid_d;
  addr_t                     buf_addr_q [NUM_REQUESTERS];
  data_t                     buf_wdata_q [NUM_REQUESTERS];
  strb_t                     buf_wstrb_q [NUM_REQUESTERS];

  logic [NUM_REQUESTERS-1:0] pend;
  addr_t                     req_addr [NUM_REQUESTERS];
  data_t                     req_wdata [NUM_REQUESTERS];
  strb_t                     req_wstrb [NUM_REQUESTERS];

  owner_t   owner_q;
  owner_t   grant_owner;
  addr_t    cur_addr_q;
  data_t    cur_wdata_q;
  strb_t    cur_wstrb_q;
  logic     busy;
  logic     free;
  logic     grant_valid;
  logic     take;
  req_idx_t grant_idx;

  // Instruction ports never write
  assign in_valid = {imem1_valid, imem0_valid, dmem1_valid, dmem0_valid};
  assign in_addr  = '{dmem0_addr, dmem1_addr, imem0_addr, imem1_addr};
  assign in_wdata = '{dmem0_wdata, dmem1_wdata, '0, '0};
  assign in_wstrb = '{dmem0_wstrb, dmem1_wstrb, '0, '0};

  // ==================================================
  // Request selection
  // ==================================================

  // A fresh pulse bypasses the buffer so it can be granted in the same cycle
  always_comb begin
    for (int i = 0; i < NUM_REQUESTERS; i++) begin
      pend[i]      = in_valid[i] || buf_valid_q[i];
      req_addr[i]  = in_valid[i] ? in_addr[i] : buf_addr_q[i];
      req_wdata[i] = in_valid[i] ? in_wdata[i] : buf_wdata_q[i];
      req_wstrb[i] = in_valid[i] ? in_wstrb[i] : buf_wstrb_q[i];
    end
  end

  // Walk from lowest to highest priority so the last hit wins
  always_comb begin
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int i = NUM_REQUESTERS - 1; i >= 0; i--) begin
      if (pend[i]) begin
        grant_valid = 1'b1;
        grant_idx   = req_idx_t'(i);
      end
    end
  end

  always_comb begin
    case (grant_idx)
      2'd0:    grant_owner = OWNER_DMEM0;
      2'd1:    grant_owner = OWNER_DMEM1;
      2'd2:    grant_owner = OWNER_IMEM0;
      default: grant_owner = OWNER_IMEM1;
    endcase
  end

  // The bus is released in the ready cycle, so a new grant may start there
  assign busy = (owner_q != OWNER_NONE) && !mem_ready;
  assign free = !busy;
  assign take = free && grant_valid;

  always_comb begin
    for (int i = 0; i < NUM_REQUESTERS; i++) begin
      buf_valid_d[i] = pend[i] && !(take && (grant_idx == req_idx_t'(i)));
    end
  end

  // ==================================================
  // Registers
  // ==================================================

  always_ff @(posedge clock) begin
    if (!reset) begin
      owner_q     <= OWNER_NONE;
      buf_valid_q <= '0;
    end else begin
      buf_valid_q <= buf_valid_d;
      if (free) begin
        owner_q <= take ? grant_owner : OWNER_NONE;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_REQUESTERS; i++) begin
      if (in_valid[i]) begin
        buf_addr_q[i]  <= in_addr[i];
        buf_wdata_q[i] <= in_wdata[i];
        buf_wstrb_q[i] <= in_wstrb[i];
      end
    end
    if (take) begin
      cur_addr_q  <= req_addr[grant_idx];
      cur_wdata_q <= req_wdata[grant_idx];
      cur_wstrb_q <= req_wstrb[grant_idx];
    end
  end

  assign mem_valid = busy || take;
  assign mem_addr  = busy ? cur_addr_q : req_addr[grant_idx];
  assign mem_wdata = busy ? cur_wdata_q : req_wdata[grant_idx];
  assign mem_wstrb = busy ? cur_wstrb_q : req_wstrb[grant_idx];

  // Responses go only to the registered owner
  assign dmem0_ready = mem_ready && (owner_q == OWNER_DMEM0);
  assign dmem1_ready = mem_ready && (owner_q == OWNER_DMEM1);
  assign imem0_ready = mem_ready && (owner_q == OWNER_IMEM0);
  assign imem1_ready = mem_ready && (owner_q == OWNER_IMEM1);
  assign dmem0_rdata = (owner_q == OWNER_DMEM0) ? mem_rdata : '0;
  assign dmem1_rdata = (owner_q == OWNER_DMEM1) ? mem_rdata : '0;
  assign imem0_rdata = (owner_q == OWNER_IMEM0) ? mem_rdata : '0;
  assign imem1_rdata = (owner_q == OWNER_IMEM1) ? mem_rdata : '0;

endmodule

/* hdl/arb_types_pkg.sv */
package arb_types_pkg;

  // Requester slots are numbered in priority order: dmem0, dmem1, imem0, imem1
  localparam int NUM_REQUESTERS = 4;
  localparam int REQ_IDX_W      = $clog2(NUM_REQUESTERS);
  typedef logic [REQ_IDX_W-1:0] req_idx_t;

  // Port that owns the access currently on the memory bus
  typedef enum logic [2:0] {
    OWNER_NONE  = 3'd0,
    OWNER_DMEM0 = 3'd1,
    OWNER_DMEM1 = 3'd2,
    OWNER_IMEM0 = 3'd3,
    OWNER_IMEM1 = 3'd4
  } owner_t;

endpackage

/* hdl/mem_types_pkg.sv */
package mem_types_pkg;

  // ==================================================
  // Bus widths
  // ==================================================

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Byte address, the two low bits are ignored by the word-addressed RAM
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // An all-zero strobe marks a read
  typedef logic [STRB_W-1:0] strb_t;

  // ==================================================
  // Shared RAM geometry and timing
  // ==================================================

  localparam int RAM_WORDS   = 1024;
  localparam int RAM_INDEX_W = $clog2(RAM_WORDS);
  typedef logic [RAM_INDEX_W-1:0] ram_index_t;

  // Cycles from the first accepted valid to the ready pulse
  localparam int RAM_LATENCY = 2;
  localparam int RAM_CNT_W   = $clog2(RAM_LATENCY + 1);
  typedef logic [RAM_CNT_W-1:0] lat_cnt_t;

endpackage
